// File: rtl/snake_consts.svh
`ifndef SNAKE_CONSTS_SVH
`define SNAKE_CONSTS_SVH

// playfield is square, outer ring of cells is the wall
`define SNAKE_GRID 16
`define SNAKE_MAX_LEN 30

`define SNAKE_START_X 8
`define SNAKE_START_Y 8
`define SNAKE_START_LEN 3
`define SNAKE_APPLE_X 4
`define SNAKE_APPLE_Y 4

`define SNAKE_TICK_CYCLES 8 // clocks between two moves while running

`endif

// File: rtl/snake_pkg.sv
package snake_pkg;

	typedef logic [3:0] coord_t;
	typedef logic [1:0] dir_t;
	typedef logic [4:0] len_t;
	typedef logic [7:0] score_t;

	// opposite headings differ only in bit 0
	localparam dir_t dir_up = 2'd0;
	localparam dir_t dir_down = 2'd1;
	localparam dir_t dir_left = 2'd2;
	localparam dir_t dir_right = 2'd3;

	typedef enum logic [1:0] {
		st_idle,
		st_run,
		st_pause,
		st_over
	} game_state_t;

endpackage

// File: rtl/button_edge.sv
`timescale 1ns/1ps

module button_edge import snake_pkg::*; (
	input logic clk,
	input logic reset,
	input logic button,
	output logic pulse
);
	logic sync_a;
	logic sync_b;
	logic prev;

	always_ff @(posedge clk) begin
		if (reset) begin
			sync_a <= 1'b0;
			sync_b <= 1'b0;
			prev <= 1'b0;
			pulse <= 1'b0;
		end else begin
			sync_a <= button;
			sync_b <= sync_a;
			prev <= sync_b;
			pulse <= sync_b && !prev; // registered so the pulse is glitch free
		end
	end

endmodule

// File: rtl/direction_control.sv
`timescale 1ns/1ps

module direction_control import snake_pkg::*; (
	input logic clk,
	input logic reset,
	input logic up_pulse,
	input logic down_pulse,
	input logic left_pulse,
	input logic right_pulse,
	input logic tick,
	input logic restart,
	output dir_t heading
);
	dir_t pending;
	dir_t request;
	dir_t base;
	logic request_valid;

	always_comb begin
		request_valid = 1'b1;
		if (up_pulse)
			request = dir_up;
		else if (down_pulse)
			request = dir_down;
		else if (left_pulse)
			request = dir_left;
		else if (right_pulse)
			request = dir_right;
		else begin
			request = pending;
			request_valid = 1'b0;
		end
	end

	// on a tick the pending turn is about to become the heading, so check against that
	assign base = tick ? pending : heading;

	always_ff @(posedge clk) begin
		if (reset || restart) begin
			heading <= dir_right;
			pending <= dir_right;
		end else begin
			if (tick)
				heading <= pending;
			if (request_valid && request != (base ^ 2'b01))
				pending <= request; // a reversal would run straight into the neck
		end
	end

endmodule

// File: rtl/game_fsm.sv
`timescale 1ns/1ps
`include "snake_consts.svh"

module game_fsm import snake_pkg::*; (
	input logic clk,
	input logic reset,
	input logic start_pulse,
	input logic hit_bad,
	output game_state_t state,
	output logic tick,
	output logic restart,
	output logic game_over
);
	localparam int tick_w = $clog2(`SNAKE_TICK_CYCLES);

	game_state_t next_state;
	logic [tick_w-1:0] tick_cnt;

	assign tick = (state == st_run) && (tick_cnt == tick_w'(`SNAKE_TICK_CYCLES - 1));
	assign restart = (state == st_over) && start_pulse;
	assign game_over = (state == st_over);

	always_comb begin
		next_state = state;
		case (state)
			st_idle: if (start_pulse) next_state = st_run;
			st_run: begin
				if (tick && hit_bad)
					next_state = st_over; // a crash wins over a pause press
				else if (start_pulse)
					next_state = st_pause;
			end
			st_pause: if (start_pulse) next_state = st_run;
			st_over: if (start_pulse) next_state = st_run;
			default: next_state = st_idle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= st_idle;
			tick_cnt <= '0;
		end else begin
			state <= next_state;
			// held at zero outside run, so every entry to run starts a full period
			if (state != st_run || tick)
				tick_cnt <= '0;
			else
				tick_cnt <= tick_cnt + 1'b1;
		end
	end

endmodule

// File: rtl/snake_body.sv
`timescale 1ns/1ps
`include "snake_consts.svh"

module snake_body import snake_pkg::*; (
	input logic clk,
	input logic reset,
	input logic restart,
	input logic tick,
	input logic hit_bad,
	input logic hit_apple,
	input dir_t heading,
	output coord_t head_x,
	output coord_t head_y,
	output coord_t next_x,
	output coord_t next_y,
	output coord_t [`SNAKE_MAX_LEN-1:0] body_x,
	output coord_t [`SNAKE_MAX_LEN-1:0] body_y,
	output len_t length,
	output score_t score,
	output logic eat
);
	logic move;

	assign move = tick && !hit_bad;
	assign head_x = body_x[0]; // segment 0 is always the head
	assign head_y = body_y[0];

	// the head never sits on the wall, so these never wrap around the grid
	always_comb begin
		next_x = head_x;
		next_y = head_y;
		case (heading)
			dir_up: next_y = head_y - 1'b1;
			dir_down: next_y = head_y + 1'b1;
			dir_left: next_x = head_x - 1'b1;
			default: next_x = head_x + 1'b1;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset || restart) begin
			for (int i = 0; i < `SNAKE_START_LEN; i++) begin
				body_x[i] <= coord_t'(`SNAKE_START_X - i); // tail trails off to the left
				body_y[i] <= coord_t'(`SNAKE_START_Y);
			end
		end else if (move) begin
			for (int i = `SNAKE_MAX_LEN - 1; i > 0; i--) begin
				body_x[i] <= body_x[i-1];
				body_y[i] <= body_y[i-1];
			end
			body_x[0] <= next_x;
			body_y[0] <= next_y;
		end
	end

	// growing just means the old tail slot, shifted one down, becomes part of the snake
	always_ff @(posedge clk) begin
		if (reset || restart) begin
			length <= len_t'(`SNAKE_START_LEN);
			score <= '0;
			eat <= 1'b0;
		end else begin
			eat <= move && hit_apple;
			if (move && hit_apple) begin
				score <= score + 1'b1;
				if (length < len_t'(`SNAKE_MAX_LEN))
					length <= length + 1'b1;
			end
		end
	end

endmodule

// File: rtl/collision_detector.sv
`timescale 1ns/1ps
`include "snake_consts.svh"

module collision_detector import snake_pkg::*; (
	input logic clk,
	input logic reset,
	input coord_t next_x,
	input coord_t next_y,
	input coord_t [`SNAKE_MAX_LEN-1:0] body_x,
	input coord_t [`SNAKE_MAX_LEN-1:0] body_y,
	input len_t length,
	input coord_t apple_x,
	input coord_t apple_y,
	input logic apple_valid,
	output logic hit_bad,
	output logic hit_apple
);
	localparam coord_t edge_max = coord_t'(`SNAKE_GRID - 1);

	logic wall_next;
	logic body_next;
	logic apple_next;

	always_comb begin
		wall_next = (next_x == '0) || (next_x == edge_max) ||
			(next_y == '0) || (next_y == edge_max);

		// the tail moves away on the same tick, so its cell is free to enter
		body_next = 1'b0;
		for (int i = 0; i < `SNAKE_MAX_LEN; i++) begin
			if (i < int'(length) - 1 && body_x[i] == next_x && body_y[i] == next_y)
				body_next = 1'b1;
		end

		apple_next = apple_valid && next_x == apple_x && next_y == apple_y;
	end

	// next_x and next_y only move right after a tick, so this settles long before the next one
	always_ff @(posedge clk) begin
		if (reset) begin
			hit_bad <= 1'b0;
			hit_apple <= 1'b0;
		end else begin
			hit_bad <= wall_next || body_next;
			hit_apple <= apple_next && !(wall_next || body_next);
		end
	end

endmodule

// File: rtl/apple_placer.sv
`timescale 1ns/1ps
`include "snake_consts.svh"

module apple_placer import snake_pkg::*; (
	input logic clk,
	input logic reset,
	input logic eat,
	input coord_t [`SNAKE_MAX_LEN-1:0] body_x,
	input coord_t [`SNAKE_MAX_LEN-1:0] body_y,
	input len_t length,
	output coord_t apple_x,
	output coord_t apple_y,
	output logic apple_valid
);
	localparam coord_t edge_max = coord_t'(`SNAKE_GRID - 1);

	logic [7:0] lfsr;
	coord_t cand_x;
	coord_t cand_y;
	logic cand_free;

	assign cand_x = lfsr[3:0];
	assign cand_y = lfsr[7:4];

	always_comb begin
		cand_free = (cand_x != '0) && (cand_x != edge_max) &&
			(cand_y != '0) && (cand_y != edge_max);
		for (int i = 0; i < `SNAKE_MAX_LEN; i++) begin
			if (i < int'(length) && body_x[i] == cand_x && body_y[i] == cand_y)
				cand_free = 1'b0;
		end
	end

	// taps 8,6,5,4 give the full 255 state cycle
	always_ff @(posedge clk) begin
		if (reset)
			lfsr <= 8'hb5;
		else
			lfsr <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			apple_x <= coord_t'(`SNAKE_APPLE_X);
			apple_y <= coord_t'(`SNAKE_APPLE_Y);
			apple_valid <= 1'b1;
		end else if (eat) begin
			apple_valid <= 1'b0;
		end else if (!apple_valid && cand_free) begin
			apple_x <= cand_x; // one candidate per clock until a free cell turns up
			apple_y <= cand_y;
			apple_valid <= 1'b1;
		end
	end

endmodule

// File: rtl/cell_renderer.sv
`timescale 1ns/1ps
`include "snake_consts.svh"

module cell_renderer import snake_pkg::*; (
	input coord_t x,
	input coord_t y,
	input coord_t head_x,
	input coord_t head_y,
	input coord_t [`SNAKE_MAX_LEN-1:0] body_x,
	input coord_t [`SNAKE_MAX_LEN-1:0] body_y,
	input len_t length,
	input coord_t apple_x,
	input coord_t apple_y,
	input logic apple_valid,
	output logic apple,
	output logic wall,
	output logic body,
	output logic head
);
	localparam coord_t edge_max = coord_t'(`SNAKE_GRID - 1);

	assign wall = (x == '0) || (x == edge_max) || (y == '0) || (y == edge_max);
	assign head = (x == head_x) && (y == head_y);
	assign apple = apple_valid && (x == apple_x) && (y == apple_y); // hidden during search

	// segment 0 is the head and gets its own flag
	always_comb begin
		body = 1'b0;
		for (int i = 1; i < `SNAKE_MAX_LEN; i++) begin
			if (i < int'(length) && body_x[i] == x && body_y[i] == y)
				body = 1'b1;
		end
	end

endmodule

// File: rtl/snake_game.sv
`timescale 1ns/1ps
`include "snake_consts.svh"

module snake_game import snake_pkg::*; (
	input logic clk,
	input logic reset,
	input logic button_up,
	input logic button_down,
	input logic button_left,
	input logic button_right,
	input logic button_start,
	input coord_t x,
	input coord_t y,
	output logic apple,
	output logic wall,
	output logic body,
	output logic head,
	output logic game_over,
	output coord_t head_x,
	output coord_t head_y,
	output coord_t apple_x,
	output coord_t apple_y,
	output score_t score
);
	logic up_pulse;
	logic down_pulse;
	logic left_pulse;
	logic right_pulse;
	logic start_pulse;
	logic tick;
	logic restart;
	logic hit_bad;
	logic hit_apple;
	logic eat;
	logic apple_valid;
	dir_t heading;
	coord_t next_x;
	coord_t next_y;
	coord_t [`SNAKE_MAX_LEN-1:0] body_x;
	coord_t [`SNAKE_MAX_LEN-1:0] body_y;
	len_t length;

	button_edge up_edge_inst (.clk(clk), .reset(reset), .button(button_up), .pulse(up_pulse));
	button_edge down_edge_inst (.clk(clk), .reset(reset), .button(button_down), .pulse(down_pulse));
	button_edge left_edge_inst (.clk(clk), .reset(reset), .button(button_left), .pulse(left_pulse));
	button_edge right_edge_inst (
		.clk(clk),
		.reset(reset),
		.button(button_right),
		.pulse(right_pulse)
	);
	button_edge start_edge_inst (
		.clk(clk),
		.reset(reset),
		.button(button_start),
		.pulse(start_pulse)
	);

	game_fsm game_fsm_inst (
		.clk(clk),
		.reset(reset),
		.start_pulse(start_pulse),
		.hit_bad(hit_bad),
		.state(), // only game_over is needed outside the FSM
		.tick(tick),
		.restart(restart),
		.game_over(game_over)
	);

	direction_control direction_control_inst (
		.clk(clk),
		.reset(reset),
		.up_pulse(up_pulse),
		.down_pulse(down_pulse),
		.left_pulse(left_pulse),
		.right_pulse(right_pulse),
		.tick(tick),
		.restart(restart),
		.heading(heading)
	);

	snake_body snake_body_inst (
		.clk(clk),
		.reset(reset),
		.restart(restart),
		.tick(tick),
		.hit_bad(hit_bad),
		.hit_apple(hit_apple),
		.heading(heading),
		.head_x(head_x),
		.head_y(head_y),
		.next_x(next_x),
		.next_y(next_y),
		.body_x(body_x),
		.body_y(body_y),
		.length(length),
		.score(score),
		.eat(eat)
	);

	collision_detector collision_detector_inst (
		.clk(clk),
		.reset(reset),
		.next_x(next_x),
		.next_y(next_y),
		.body_x(body_x),
		.body_y(body_y),
		.length(length),
		.apple_x(apple_x),
		.apple_y(apple_y),
		.apple_valid(apple_valid),
		.hit_bad(hit_bad),
		.hit_apple(hit_apple)
	);

	apple_placer apple_placer_inst (
		.clk(clk),
		.reset(reset),
		.eat(eat),
		.body_x(body_x),
		.body_y(body_y),
		.length(length),
		.apple_x(apple_x),
		.apple_y(apple_y),
		.apple_valid(apple_valid)
	);

	cell_renderer cell_renderer_inst (
		.x(x),
		.y(y),
		.head_x(head_x),
		.head_y(head_y),
		.body_x(body_x),
		.body_y(body_y),
		.length(length),
		.apple_x(apple_x),
		.apple_y(apple_y),
		.apple_valid(apple_valid),
		.apple(apple),
		.wall(wall),
		.body(body),
		.head(head)
	);

endmodule

// File: testbench/snake_game_tb.sv
`timescale 1ns/1ps
`include "snake_consts.svh"

module snake_game_tb import snake_pkg::*; ();
	localparam int btn_start = 4;
	localparam int no_press = -1;
	localparam coord_t edge_max = coord_t'(`SNAKE_GRID - 1);

	logic clk = 1'b0;
	logic reset;
	logic button_up;
	logic button_down;
	logic button_left;
	logic button_right;
	logic button_start;
	coord_t x;
	coord_t y;
	logic apple;
	logic wall;
	logic body;
	logic head;
	logic game_over;
	coord_t head_x;
	coord_t head_y;
	coord_t apple_x;
	coord_t apple_y;
	score_t score;

	logic [15:0] lfsr_state;
	coord_t last_x;
	coord_t last_y;
	coord_t ref_apple_x;
	coord_t ref_apple_y;
	dir_t ref_heading;
	dir_t ref_pending;
	int exp_score;
	logic ate;
	logic over;
	logic moved;
	int rounds;

	snake_game snake_game_inst (
		.clk(clk),
		.reset(reset),
		.button_up(button_up),
		.button_down(button_down),
		.button_left(button_left),
		.button_right(button_right),
		.button_start(button_start),
		.x(x),
		.y(y),
		.apple(apple),
		.wall(wall),
		.body(body),
		.head(head),
		.game_over(game_over),
		.head_x(head_x),
		.head_y(head_y),
		.apple_x(apple_x),
		.apple_y(apple_y),
		.score(score)
	);

	always #20 clk = ~clk;

	task automatic report_failure(input string what);
		$display("ERROR at %0t: %s", $time, what);
		$display("Testbench failed");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string name, input int got, input int expected);
		$display("MISMATCH at %0t: %s is %0d, expected %0d", $time, name, got, expected);
		$display("Testbench failed");
		$fatal(1);
	endtask

	// x^16 + x^15 + x^13 + x^4 + 1
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		logic fb;
		fb = s[15] ^ s[14] ^ s[12] ^ s[3];
		return {s[14:0], fb};
	endfunction

	task automatic take_random_bit(output logic b);
		lfsr_state = lfsr_step(lfsr_state);
		b = lfsr_state[0];
	endtask

	function automatic coord_t move_x(input coord_t cx, input dir_t d);
		if (d == dir_left)
			return cx - 4'd1;
		if (d == dir_right)
			return cx + 4'd1;
		return cx;
	endfunction

	function automatic coord_t move_y(input coord_t cy, input dir_t d);
		if (d == dir_up)
			return cy - 4'd1;
		if (d == dir_down)
			return cy + 4'd1;
		return cy;
	endfunction

	function automatic dir_t opposite_of(input dir_t d);
		case (d)
			dir_up: return dir_down;
			dir_down: return dir_up;
			dir_left: return dir_right;
			default: return dir_left;
		endcase
	endfunction

	function automatic logic on_border(input coord_t cx, input coord_t cy);
		return cx == 4'd0 || cx == edge_max || cy == 4'd0 || cy == edge_max;
	endfunction

	// idx follows the heading codes, btn_start is the fifth button
	task automatic drive_button(input int idx, input logic level);
		case (idx)
			0: button_up = level;
			1: button_down = level;
			2: button_left = level;
			3: button_right = level;
			default: button_start = level;
		endcase
	endtask

	task automatic press_button(input int idx);
		drive_button(idx, 1'b1);
		repeat (2) @(negedge clk);
		drive_button(idx, 1'b0);
		repeat (4) @(negedge clk); // the pulse is over by now
	endtask

	task automatic query_cell(input coord_t qx, input coord_t qy);
		x = qx;
		y = qy;
		#2;
	endtask

	task automatic wait_head_event(output logic changed, output logic ended);
		int count;
		changed = 1'b0;
		ended = 1'b0;
		count = 0;
		while (!changed && !ended) begin
			@(negedge clk);
			count++;
			if (game_over)
				ended = 1'b1;
			else if (head_x != last_x || head_y != last_y)
				changed = 1'b1;
			else if (count > 40)
				report_failure("head did not move within 40 cycles");
		end
	endtask

	task automatic check_step(output logic eaten);
		coord_t ex;
		coord_t ey;
		ex = move_x(last_x, ref_heading);
		ey = move_y(last_y, ref_heading);
		assert (head_x == ex) else report_mismatch("head_x", head_x, ex);
		assert (head_y == ey) else report_mismatch("head_y", head_y, ey);
		eaten = (ex == ref_apple_x && ey == ref_apple_y);
		if (eaten)
			exp_score++;
		assert (score == exp_score) else report_mismatch("score", score, exp_score);
		last_x = ex;
		last_y = ey;
		ref_heading = ref_pending; // the queued turn takes over on the same tick
	endtask

	// steers toward a target from the cell the head enters next
	task automatic choose_press(input coord_t tx, input coord_t ty, output int btn);
		coord_t px;
		coord_t py;
		int want_x;
		int want_y;
		int along;
		int across;
		logic turn_now;
		logic try_reverse;
		px = move_x(last_x, ref_heading);
		py = move_y(last_y, ref_heading);
		want_x = (tx < px) ? int'(dir_left) : (tx > px) ? int'(dir_right) : no_press;
		want_y = (ty < py) ? int'(dir_up) : (ty > py) ? int'(dir_down) : no_press;
		if (ref_heading == dir_left || ref_heading == dir_right) begin
			along = want_x;
			across = want_y;
		end else begin
			along = want_y;
			across = want_x;
		end
		take_random_bit(turn_now);
		take_random_bit(try_reverse);
		if (on_border(px, py))
			btn = no_press;
		else if (along == no_press)
			btn = across;
		else if (along == int'(ref_heading))
			btn = (across != no_press && turn_now) ? across : no_press;
		else if (across != no_press)
			btn = across;
		else if (ref_heading == dir_left || ref_heading == dir_right)
			btn = (py >= 4'd3) ? int'(dir_up) : int'(dir_down); // detour around a reversal
		else
			btn = (px >= 4'd3) ? int'(dir_left) : int'(dir_right);
		if (btn == no_press && try_reverse && !on_border(px, py))
			btn = int'(opposite_of(ref_heading));
	endtask

	task automatic apply_press(input int btn);
		if (dir_t'(btn) != opposite_of(ref_heading))
			ref_pending = dir_t'(btn);
		press_button(btn);
	endtask

	task automatic drive_toward(input coord_t tx, input coord_t ty, output logic eaten,
		output logic ended);
		logic changed;
		int steps;
		int btn;
		eaten = 1'b0;
		ended = 1'b0;
		steps = 0;
		while (!eaten && !ended) begin
			wait_head_event(changed, ended);
			if (!ended) begin
				check_step(eaten);
				if (!eaten) begin
					choose_press(tx, ty, btn);
					if (btn != no_press)
						apply_press(btn);
				end
				steps++;
				if (steps > 80)
					report_failure("snake did not reach its target cell in 80 steps");
			end
		end
	endtask

	// pause, wait for the new apple, check its cell, then resume
	task automatic handle_eat;
		int count;
		logic found;
		press_button(btn_start);
		found = 1'b0;
		count = 0;
		while (!found) begin
			@(negedge clk);
			assert (head_x == last_x) else report_mismatch("head_x", head_x, last_x);
			assert (head_y == last_y) else report_mismatch("head_y", head_y, last_y);
			query_cell(apple_x, apple_y);
			found = apple;
			count++;
			if (!found && count > 300)
				report_failure("no new apple appeared after the apple was eaten");
		end
		assert (!wall) else report_mismatch("wall", wall, 0);
		assert (!body) else report_mismatch("body", body, 0);
		assert (!head) else report_mismatch("head", head, 0);
		ref_apple_x = apple_x;
		ref_apple_y = apple_y;
		repeat (24) begin
			@(negedge clk);
			assert (head_x == last_x) else report_mismatch("head_x", head_x, last_x);
			assert (head_y == last_y) else report_mismatch("head_y", head_y, last_y);
			assert (!game_over) else report_mismatch("game_over", game_over, 0);
		end
		press_button(btn_start);
	endtask

	initial begin
		lfsr_state = 16'd30;
		reset = 1'b1;
		button_up = 1'b0;
		button_down = 1'b0;
		button_left = 1'b0;
		button_right = 1'b0;
		button_start = 1'b0;
		x = '0;
		y = '0;
		repeat (5) @(negedge clk);
		reset = 1'b0;
		@(negedge clk);

		assert (head_x == 4'd8) else report_mismatch("head_x", head_x, 8);
		assert (head_y == 4'd8) else report_mismatch("head_y", head_y, 8);
		assert (score == 8'd0) else report_mismatch("score", score, 0);
		assert (!game_over) else report_mismatch("game_over", game_over, 0);
		assert (apple_x == 4'd4) else report_mismatch("apple_x", apple_x, 4);
		assert (apple_y == 4'd4) else report_mismatch("apple_y", apple_y, 4);
		query_cell(4'd8, 4'd8);
		assert (head) else report_mismatch("head", head, 1);
		query_cell(4'd7, 4'd8);
		assert (body) else report_mismatch("body", body, 1);
		query_cell(4'd0, 4'd5);
		assert (wall) else report_mismatch("wall", wall, 1);
		query_cell(4'd4, 4'd4);
		assert (apple) else report_mismatch("apple", apple, 1);

		last_x = coord_t'(`SNAKE_START_X);
		last_y = coord_t'(`SNAKE_START_Y);
		ref_heading = dir_right;
		ref_pending = dir_right;
		exp_score = 0;
		ref_apple_x = 4'd4;
		ref_apple_y = 4'd4;

		@(negedge clk);
		press_button(btn_start);
		drive_toward(4'd4, 4'd4, ate, over);
		if (over)
			report_failure("game ended before the first apple was reached");
		handle_eat;

		// head for the top wall, eating whatever apple lies on the way
		over = 1'b0;
		rounds = 0;
		while (!over) begin
			drive_toward(4'd7, 4'd0, ate, over);
			if (ate)
				handle_eat;
			rounds++;
			if (!over && rounds > 5)
				report_failure("snake never ran into the wall");
		end
		assert (on_border(move_x(last_x, ref_heading), move_y(last_y, ref_heading)))
			else report_failure("game ended without a wall in front of the head");
		repeat (24) begin
			@(negedge clk);
			assert (head_x == last_x) else report_mismatch("head_x", head_x, last_x);
			assert (head_y == last_y) else report_mismatch("head_y", head_y, last_y);
			assert (game_over) else report_mismatch("game_over", game_over, 1);
		end

		press_button(btn_start);
		assert (head_x == 4'd8) else report_mismatch("head_x", head_x, 8);
		assert (head_y == 4'd8) else report_mismatch("head_y", head_y, 8);
		assert (score == 8'd0) else report_mismatch("score", score, 0);
		assert (!game_over) else report_mismatch("game_over", game_over, 0);
		last_x = 4'd8;
		last_y = 4'd8;
		ref_heading = dir_right;
		ref_pending = dir_right;
		exp_score = 0;
		// the restarted snake takes one step to the right
		wait_head_event(moved, over);
		if (!moved)
			report_failure("game ended on the first step after the restart");
		check_step(ate);
		$display("Testbench passed");
		$finish;
	end

endmodule

// File: tb.f
+incdir+rtl
rtl/snake_pkg.sv
rtl/button_edge.sv
rtl/direction_control.sv
rtl/game_fsm.sv
rtl/snake_body.sv
rtl/collision_detector.sv
rtl/apple_placer.sv
rtl/cell_renderer.sv
rtl/snake_game.sv
testbench/snake_game_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module snake_game_tb -f tb.f \
	-o snake_sim && ./obj_dir/snake_sim > sim.log 2>&1
grep -qx "Testbench passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
